/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tcb_sys_tb -f tb.f -o sim_tcb

# keep the output for the pass search, a crash still reaches it
out=$(./obj_dir/sim_tcb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***'

/* tb.f */
+incdir+.
tcb_pkg.sv
tcb_if.sv
tcb_lib_arb.sv
tcb_lib_mux.sv
tcb_mem.sv
tcb_sys.sv
tcb_sys_tb.sv

/* tcb_if.sv */
`timescale 1ns/1ps
`include "tcb_params.svh"

interface tcb_if (
  input logic man,
  input logic arst_n
);

  //////////////////////////////////////////////////
  // signals
  //////////////////////////////////////////////////

  // request
  logic                vld;
  logic                wen;
  logic [`TCB_ABW-1:0] adr;
  logic [`TCB_BEW-1:0] ben;
  logic [`TCB_DBW-1:0] wdt;
  // arbitration lock, repeat hint
  logic                lck;
  logic                rpt;
  // request phase handshake
  logic                rdy;
  // response, one cycle after trn
  logic [`TCB_DBW-1:0] rdt;
  logic                err;
  // transfer strobe
  logic                trn;

  assign trn = vld & rdy;

  // manager side drives the request
  modport mgr (
    output vld, wen, adr, ben, wdt, lck, rpt,
    input  rdy, rdt, err, trn
  );

  // subordinate side answers it
  modport sub (
    input  vld, wen, adr, ben, wdt, lck, rpt, trn,
    output rdy, rdt, err
  );

  //////////////////////////////////////////////////
  // protocol check
  //////////////////////////////////////////////////

  // stalled request must not move or drop
  a_req_hold: assert property (
    @(posedge man) disable iff (!arst_n)
    vld && !rdy |=> vld && $stable({wen, adr, ben, wdt, lck, rpt})
  ) else $error("tcb_if: request changed while stalled");

endinterface

/* tcb_input.dat */
// grp mgr lck wen adr ben wdt exp_rdt exp_err, all hex
// one access per line, equal grp values start in the same cycle
// single manager write then read
01 0 0 1 00 f deadbeef 00000000 0
02 0 0 0 00 0 00000000 deadbeef 0
03 1 0 1 40 f cafef00d 00000000 0
04 1 0 0 40 0 00000000 cafef00d 0
// byte enables
05 0 0 1 08 f aabbccdd 00000000 0
06 0 0 1 08 3 11223344 00000000 0
07 1 0 1 08 8 55667788 00000000 0
08 1 0 0 08 0 00000000 55bb3344 0
09 0 0 1 08 6 99999999 00000000 0
0a 0 0 0 08 0 00000000 55999944 0
// out of range, 80 and c0 alias words 00 and 40
0b 0 0 1 80 f 12345678 00000000 1
0c 1 0 1 c0 f 87654321 00000000 1
0d 0 0 0 fc 0 00000000 00000000 1
0e 0 0 0 00 0 00000000 deadbeef 0
0e 1 0 0 40 0 00000000 cafef00d 0
// contested groups
0f 0 0 1 10 f 10101010 00000000 0
0f 1 0 1 14 f 14141414 00000000 0
10 0 0 0 14 0 00000000 14141414 0
10 1 0 0 10 0 00000000 10101010 0
11 0 0 0 90 0 00000000 00000000 1
11 1 0 0 08 0 00000000 55999944 0
// locked transfers
12 0 1 1 20 f 20202020 00000000 0
13 0 0 0 20 0 00000000 20202020 0
13 1 0 0 00 0 00000000 deadbeef 0
14 1 1 1 24 f 24242424 00000000 0
15 0 0 0 24 0 00000000 24242424 0
15 1 0 0 20 0 00000000 20202020 0
16 0 1 1 28 f 28282828 00000000 0
16 1 0 1 2c f 2c2c2c2c 00000000 0
17 0 0 0 2c 0 00000000 2c2c2c2c 0
17 1 0 0 28 0 00000000 28282828 0

/* tcb_lib_arb.sv */
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_lib_arb import tcb_pkg::*; #(
  // manager port count
  parameter  int unsigned PN = `TCB_PN,
  localparam int unsigned PL = $clog2(PN)
)(
  input  logic          man,
  input  logic          arst_n,
  // per manager request and lock
  input  logic [PN-1:0] vld,
  input  logic [PN-1:0] lck,
  // memory side transfer
  input  logic          trn,
  // mux select
  output logic [PL-1:0] sel
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // last granted port, start of the rr search
  logic [PL-1:0] lst;
  // value loaded into lst on a transfer
  logic [PL-1:0] lst_nxt;
  // port just before the selected one
  logic [PL-1:0] sel_prv;

  //////////////////////////////////////////////////
  // select
  //////////////////////////////////////////////////

  // combinational from live requests
  assign sel = rr_next(vld, lst);

  // wrap below port 0
  assign sel_prv = (sel == '0) ? PL'(PN-1) : sel - 1'b1;

  // locked transfer
  // pretend the previous port won, so sel is searched first next time
  assign lst_nxt = lck[sel] ? sel_prv : sel;

  // last grant only moves on a transfer
  always_ff @(posedge man or negedge arst_n) begin
    if (!arst_n) begin
      lst <= '0;
    end else if (trn) begin
      lst <= lst_nxt;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // grant always lands on a requester
  a_sel_req: assert property (
    @(posedge man) disable iff (!arst_n)
    |vld |-> vld[sel]
  ) else $error("tcb_lib_arb: select points at idle port");

  // locking port wins again next cycle if it still requests
  a_lck_keep: assert property (
    @(posedge man) disable iff (!arst_n)
    trn && lck[sel] |=> !vld[$past(sel)] || sel == $past(sel)
  ) else $error("tcb_lib_arb: locked grant lost");

endmodule

/* tcb_lib_mux.sv */
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_lib_mux #(
  // manager port count
  parameter  int unsigned PN = `TCB_PN,
  localparam int unsigned PL = $clog2(PN)
)(
  input  logic          man,
  input  logic          arst_n,
  // request select from arbiter
  input  logic [PL-1:0] sel,
  // manager facing ports
  tcb_if.sub            sub [PN-1:0],
  // memory facing port
  tcb_if.mgr            mgr
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  // registered select for the response phase
  logic [PL-1:0]       rsp_sel;

  // flattened request, interface arrays need a constant index
  logic                tmp_vld [PN-1:0];
  logic                tmp_wen [PN-1:0];
  logic [`TCB_ABW-1:0] tmp_adr [PN-1:0];
  logic [`TCB_BEW-1:0] tmp_ben [PN-1:0];
  logic [`TCB_DBW-1:0] tmp_wdt [PN-1:0];
  logic                tmp_lck [PN-1:0];
  logic                tmp_rpt [PN-1:0];

  // ready per manager
  logic [PN-1:0]       tmp_rdy;

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  for (genvar i = 0; i < PN; i++) begin : gen_req
    assign tmp_vld[i] = sub[i].vld;
    assign tmp_wen[i] = sub[i].wen;
    assign tmp_adr[i] = sub[i].adr;
    assign tmp_ben[i] = sub[i].ben;
    assign tmp_wdt[i] = sub[i].wdt;
    assign tmp_lck[i] = sub[i].lck;
    assign tmp_rpt[i] = sub[i].rpt;
  end

  // selected manager straight through
  assign mgr.vld = tmp_vld[sel];
  assign mgr.wen = tmp_wen[sel];
  assign mgr.adr = tmp_adr[sel];
  assign mgr.ben = tmp_ben[sel];
  assign mgr.wdt = tmp_wdt[sel];
  assign mgr.lck = tmp_lck[sel];
  // not acted on, passed along
  assign mgr.rpt = tmp_rpt[sel];

  //////////////////////////////////////////////////
  // response path
  //////////////////////////////////////////////////

  // remember who issued the transfer
  always_ff @(posedge man or negedge arst_n) begin
    if (!arst_n) begin
      rsp_sel <= '0;
    end else if (mgr.trn) begin
      rsp_sel <= sel;
    end
  end

  for (genvar i = 0; i < PN; i++) begin : gen_rsp
    // ready only to the selected and requesting manager
    assign tmp_rdy[i]  = (sel == PL'(i)) & tmp_vld[i] & mgr.rdy;
    assign sub[i].rdy  = tmp_rdy[i];
    // response to the issuer, zero elsewhere
    assign sub[i].rdt  = (rsp_sel == PL'(i)) ? mgr.rdt : '0;
    assign sub[i].err  = (rsp_sel == PL'(i)) ? mgr.err : 1'b0;
  end

  // err reaches only the manager that handshook one cycle before
  for (genvar i = 0; i < PN; i++) begin : gen_chk
    a_rsp_own: assert property (
      @(posedge man) disable iff (!arst_n)
      sub[i].err |-> $past(tmp_rdy[i])
    ) else $error("tcb_lib_mux: response at port without transfer");
  end

endmodule

/* tcb_mem.sv */
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_mem import tcb_pkg::*; (
  input logic man,
  input logic arst_n,
  // bus from the mux
  tcb_if.sub  bus
);

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  // word index width
  localparam int unsigned AW = $clog2(`TCB_MEM_DEPTH);
  // byte offset width inside a word
  localparam int unsigned OW = $clog2(`TCB_BEW);

  // storage
  logic [`TCB_DBW-1:0] mem [`TCB_MEM_DEPTH];

  // word index from address bits above the byte offset
  logic [AW-1:0]       idx;
  // address falls inside the array
  logic                in_rng;
  // registered read word
  logic [`TCB_DBW-1:0] rdt_q;
  // registered error flag
  logic                err_q;

  assign idx    = bus.adr[OW +: AW];
  // any bit above the index means out of range
  assign in_rng = ~|bus.adr[`TCB_ABW-1:OW+AW];

  // never stalls
  assign bus.rdy = 1'b1;

  //////////////////////////////////////////////////
  // write and read
  //////////////////////////////////////////////////

  // byte lane write
  always_ff @(posedge man) begin
    if (bus.trn && bus.wen && in_rng) begin
      mem[idx] <= ben_merge(mem[idx], bus.wdt, bus.ben);
    end
  end

  // read word lands one cycle after trn
  // writes leave rdt as it was
  always_ff @(posedge man) begin
    if (bus.trn && !bus.wen && in_rng) begin
      rdt_q <= mem[idx];
    end
  end

  // error for out of range, reads and writes alike
  always_ff @(posedge man or negedge arst_n) begin
    if (!arst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus.trn & ~in_rng;
    end
  end

  assign bus.rdt = rdt_q;
  assign bus.err = err_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // err only in the response to an access past the last word
  a_err_rsp: assert property (
    @(posedge man) disable iff (!arst_n)
    bus.err |-> $past(bus.trn && (bus.adr >= `TCB_BEW * `TCB_MEM_DEPTH), `TCB_DLY)
  ) else $error("tcb_mem: err without out of range transfer");

endmodule

/* tcb_params.svh */
`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

// byte address width
`define TCB_ABW 8
// data width
`define TCB_DBW 32
// one enable per byte lane
`define TCB_BEW (`TCB_DBW/8)

//////////////////////////////////////////////////
// system
//////////////////////////////////////////////////

// response delay in cycles, fixed
`define TCB_DLY 1
// manager port count
`define TCB_PN 2
// memory depth in words
`define TCB_MEM_DEPTH 32

`endif

/* tcb_pkg.sv */
`include "tcb_params.svh"

package tcb_pkg;

  // merge new bytes into old word where enabled
  function automatic logic [`TCB_DBW-1:0] ben_merge(
    input logic [`TCB_DBW-1:0] old_wrd,
    input logic [`TCB_DBW-1:0] new_wrd,
    input logic [`TCB_BEW-1:0] ben
  );
    logic [`TCB_DBW-1:0] res;
    res = old_wrd;
    for (int b = 0; b < `TCB_BEW; b++) begin
      if (ben[b]) res[8*b +: 8] = new_wrd[8*b +: 8];
    end
    return res;
  endfunction

  // first requesting port after the last grant
  // walks backwards so the nearest port is assigned last
  // no request keeps the last grant
  function automatic logic [$clog2(`TCB_PN)-1:0] rr_next(
    input logic [`TCB_PN-1:0]         req,
    input logic [$clog2(`TCB_PN)-1:0] lst
  );
    int                         idx;
    logic [$clog2(`TCB_PN)-1:0] nxt;
    nxt = lst;
    for (int i = `TCB_PN; i >= 1; i--) begin
      idx = (int'(lst) + i) % `TCB_PN;
      if (req[idx]) nxt = idx[$clog2(`TCB_PN)-1:0];
    end
    return nxt;
  endfunction

endpackage

/* tcb_sys.sv */
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_sys (
  input  logic                man,
  input  logic                arst_n,
  // manager 0 request
  input  logic                m0_vld,
  input  logic                m0_wen,
  input  logic [`TCB_ABW-1:0] m0_adr,
  input  logic [`TCB_BEW-1:0] m0_ben,
  input  logic [`TCB_DBW-1:0] m0_wdt,
  input  logic                m0_lck,
  // manager 0 handshake and response
  output logic                m0_rdy,
  output logic [`TCB_DBW-1:0] m0_rdt,
  output logic                m0_err,
  // manager 1 request
  input  logic                m1_vld,
  input  logic                m1_wen,
  input  logic [`TCB_ABW-1:0] m1_adr,
  input  logic [`TCB_BEW-1:0] m1_ben,
  input  logic [`TCB_DBW-1:0] m1_wdt,
  input  logic                m1_lck,
  // manager 1 handshake and response
  output logic                m1_rdy,
  output logic [`TCB_DBW-1:0] m1_rdt,
  output logic                m1_err
);

  //////////////////////////////////////////////////
  // buses
  //////////////////////////////////////////////////

  localparam int unsigned PL = $clog2(`TCB_PN);

  // one bus per manager
  tcb_if bus_mgr [`TCB_PN-1:0] (.man(man), .arst_n(arst_n));
  // shared bus toward the memory
  tcb_if bus_mem (.man(man), .arst_n(arst_n));

  // arbiter inputs gathered per port
  logic [`TCB_PN-1:0] arb_vld;
  logic [`TCB_PN-1:0] arb_lck;
  // arbiter to mux select
  logic [PL-1:0]      arb_sel;

  // manager 0 ports onto its bus
  assign bus_mgr[0].vld = m0_vld;
  assign bus_mgr[0].wen = m0_wen;
  assign bus_mgr[0].adr = m0_adr;
  assign bus_mgr[0].ben = m0_ben;
  assign bus_mgr[0].wdt = m0_wdt;
  assign bus_mgr[0].lck = m0_lck;
  // no repeat access
  assign bus_mgr[0].rpt = 1'b0;
  assign m0_rdy         = bus_mgr[0].rdy;
  assign m0_rdt         = bus_mgr[0].rdt;
  assign m0_err         = bus_mgr[0].err;

  // manager 1 likewise
  assign bus_mgr[1].vld = m1_vld;
  assign bus_mgr[1].wen = m1_wen;
  assign bus_mgr[1].adr = m1_adr;
  assign bus_mgr[1].ben = m1_ben;
  assign bus_mgr[1].wdt = m1_wdt;
  assign bus_mgr[1].lck = m1_lck;
  assign bus_mgr[1].rpt = 1'b0;
  assign m1_rdy         = bus_mgr[1].rdy;
  assign m1_rdt         = bus_mgr[1].rdt;
  assign m1_err         = bus_mgr[1].err;

  for (genvar i = 0; i < `TCB_PN; i++) begin : gen_arb
    assign arb_vld[i] = bus_mgr[i].vld;
    assign arb_lck[i] = bus_mgr[i].lck;
  end

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////

  // round robin with lock
  tcb_lib_arb #(
    .PN     (`TCB_PN)
  ) u_arb (
    .man    (man),
    .arst_n (arst_n),
    .vld    (arb_vld),
    .lck    (arb_lck),
    .trn    (bus_mem.trn),
    .sel    (arb_sel)
  );

  // request mux, response demux
  tcb_lib_mux #(
    .PN     (`TCB_PN)
  ) u_mux (
    .man    (man),
    .arst_n (arst_n),
    .sel    (arb_sel),
    .sub    (bus_mgr),
    .mgr    (bus_mem)
  );

  // the only subordinate
  tcb_mem u_mem (
    .man    (man),
    .arst_n (arst_n),
    .bus    (bus_mem)
  );

endmodule

/* tcb_sys_tb.sv */
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_sys_tb;

  //////////////////////////////////////////////////
  // setup
  //////////////////////////////////////////////////

  // words per access line in the data file
  localparam int NF = 9;
  // room for this many access lines
  localparam int NL = 64;
  // cycles a manager waits for rdy
  localparam int RDY_TMO = 20;

  logic                man;
  logic                arst_n;
  // per manager request
  logic                vld [2];
  logic                wen [2];
  logic [`TCB_ABW-1:0] adr [2];
  logic [`TCB_BEW-1:0] ben [2];
  logic [`TCB_DBW-1:0] wdt [2];
  logic                lck [2];
  // per manager handshake and response
  logic                rdy [2];
  logic [`TCB_DBW-1:0] rdt [2];
  logic                err [2];

  // raw data file words, NF per line
  logic [31:0] vec [NF*NL];
  int          n_lines;
  int          errors;
  int          timeouts;
  // port that should win the next contest
  int          prio;
  // ports in the order their rdy was seen
  int          grant_q [$];
  // line per manager in the current group, -1 when idle
  int          slot [2];

  tcb_sys u_tcb_sys (
    .man    (man),    .arst_n (arst_n),
    .m0_vld (vld[0]), .m0_wen (wen[0]), .m0_adr (adr[0]), .m0_ben (ben[0]),
    .m0_wdt (wdt[0]), .m0_lck (lck[0]), .m0_rdy (rdy[0]), .m0_rdt (rdt[0]),
    .m0_err (err[0]),
    .m1_vld (vld[1]), .m1_wen (wen[1]), .m1_adr (adr[1]), .m1_ben (ben[1]),
    .m1_wdt (wdt[1]), .m1_lck (lck[1]), .m1_rdy (rdy[1]), .m1_rdt (rdt[1]),
    .m1_err (err[1])
  );

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one access on manager m, called 5 ns after a rising edge
  task automatic run_access(input int m, input int ln);
    int cnt;
    bit got;
    cnt    = 0;
    got    = 1'b0;
    lck[m] = vec[NF*ln+2][0];
    wen[m] = vec[NF*ln+3][0];
    adr[m] = vec[NF*ln+4][`TCB_ABW-1:0];
    ben[m] = vec[NF*ln+5][`TCB_BEW-1:0];
    wdt[m] = vec[NF*ln+6];
    vld[m] = 1'b1;
    // rdy is settled mid cycle
    while (!got && cnt < RDY_TMO) begin
      @(negedge man);
      if (rdy[m]) got = 1'b1;
      else cnt++;
    end
    if (got) grant_q.push_back(m);
    else begin
      timeouts++;
      $display("timeout: manager %0d never saw rdy for line %0d", m, ln);
    end
    // transfer on this edge
    @(posedge man);
    #5;
    vld[m] = 1'b0;
    lck[m] = 1'b0;
    if (got) begin
      // response cycle
      @(negedge man);
      check_value($sformatf("line %0d err", ln), 32'(err[m]), vec[NF*ln+8]);
      // reads in range carry data
      if (!wen[m] && !vec[NF*ln+8][0]) begin
        check_value($sformatf("line %0d rdt", ln), rdt[m], vec[NF*ln+7]);
      end
    end
  endtask

  // round robin model, one contest winner per group
  task automatic check_grant_order();
    int exp_q [$];
    int m;
    if (slot[0] >= 0 && slot[1] >= 0) begin
      exp_q.push_back(prio);
      exp_q.push_back(1 - prio);
    end else begin
      exp_q.push_back(slot[0] >= 0 ? 0 : 1);
    end
    check_value("grant count", grant_q.size(), exp_q.size());
    foreach (exp_q[k]) begin
      m = exp_q[k];
      if (k < grant_q.size()) check_value("grant order", grant_q[k], m);
      // a locked transfer keeps priority, otherwise it passes on
      prio = vec[NF*slot[m]+2][0] ? m : 1 - m;
    end
  endtask

  //////////////////////////////////////////////////
  // clock and run
  //////////////////////////////////////////////////

  initial begin
    man = 1'b0;
    forever #50 man = ~man;
  end

  initial begin
    int i;
    int gap;
    logic [31:0] grp;
    errors   = 0;
    timeouts = 0;
    prio     = 1;
    n_lines  = 0;
    void'($urandom(67));
    arst_n   = 1'b0;
    for (int p = 0; p < 2; p++) begin
      vld[p] = 1'b0;
      wen[p] = 1'b0;
      adr[p] = '0;
      ben[p] = '0;
      wdt[p] = '0;
      lck[p] = 1'b0;
    end
    // all ones marks unused lines
    for (int k = 0; k < NF*NL; k++) vec[k] = '1;
    $readmemh("tcb_input.dat", vec);
    while (n_lines < NL && vec[NF*n_lines] != '1) n_lines++;
    if (n_lines == 0) begin
      errors++;
      $display("no access lines could be read from tcb_input.dat");
    end
    repeat (16) @(posedge man);
    #5;
    arst_n = 1'b1;
    // idle bus gives no rdy
    @(negedge man);
    check_value("idle rdy m0", 32'(rdy[0]), 0);
    check_value("idle rdy m1", 32'(rdy[1]), 0);

    i = 0;
    while (i < n_lines) begin
      // gather one group
      grp     = vec[NF*i];
      slot[0] = -1;
      slot[1] = -1;
      while (i < n_lines && vec[NF*i] == grp) begin
        slot[vec[NF*i+1][0]] = i;
        i++;
      end
      gap = $urandom % 3;
      repeat (gap) @(posedge man);
      @(posedge man);
      #5;
      grant_q.delete();
      fork
        if (slot[0] >= 0) run_access(0, slot[0]);
        if (slot[1] >= 0) run_access(1, slot[1]);
      join
      check_grant_order();
    end

    $display("%0d lines, %0d errors, %0d timeouts", n_lines, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
